//--- Bender.yml
package:
  name: task_injector

sources:
  - task_injector_pkg.sv
  - injector_ctrl.sv
  - packet_sender.sv
  - packet_receiver.sv
  - task_injector.sv
  - target: simulation
    files:
      - tb_task_injector.sv

//--- injector_ctrl.sv
// application sequencer of the task injector
// captures preamble and size words, counts tasks, requests packets
`timescale 1ns/1ns

module injector_ctrl (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         src_valid_i,
    output logic                                         src_ready_o,
    input  task_injector_pkg::flit_t                     src_data_i,
    output logic                                         send_valid_o,
    output task_injector_pkg::pkt_kind_t                 send_kind_o,
    input  logic                                         send_ready_i,
    input  logic                                         send_done_i,
    input  logic                                         req_event_i,
    input  logic                                         alloc_event_i,
    input  logic                                         complete_event_i,
    output task_injector_pkg::flit_t                     graph_size_o,
    output task_injector_pkg::flit_t                     app_hash_o,
    output task_injector_pkg::flit_t                     task_cnt_o,
    output task_injector_pkg::flit_t                     text_size_o,
    output task_injector_pkg::flit_t                     data_size_o,
    output task_injector_pkg::flit_t                     bss_size_o,
    output task_injector_pkg::flit_t                     entry_o,
    output logic [task_injector_pkg::TASK_IDX_W-1:0]     task_idx_o
);

    typedef enum logic [12:0] {
        ST_SIZE       = 13'h0001,
        ST_HASH       = 13'h0002,
        ST_COUNT      = 13'h0004,
        ST_DATA_AV    = 13'h0008,
        ST_WAIT_REQ   = 13'h0010,
        ST_DESCR      = 13'h0020,
        ST_WAIT_ALLOC = 13'h0040,
        ST_TEXT       = 13'h0080,
        ST_DATA       = 13'h0100,
        ST_BSS        = 13'h0200,
        ST_ENTRY      = 13'h0400,
        ST_TASK       = 13'h0800,
        ST_WAIT_DONE  = 13'h1000
    } state_t;

    state_t state_q, state_d;
    logic   take;
    logic   last_task;
    logic   req_taken_q;

    task_injector_pkg::flit_t                 task_cnt_q;
    logic [task_injector_pkg::TASK_IDX_W-1:0] task_idx_q;

    assign src_ready_o = state_q inside {ST_SIZE, ST_HASH, ST_COUNT,
                                         ST_TEXT, ST_DATA, ST_BSS, ST_ENTRY};
    assign take        = src_valid_i && src_ready_o;
    assign last_task   = (32'(task_idx_q) + 32'd1) >= task_cnt_q;

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_SIZE:       if (take) state_d = ST_HASH;
            ST_HASH:       if (take) state_d = ST_COUNT;
            ST_COUNT:      if (take) state_d = ST_DATA_AV;
            ST_DATA_AV:    if (send_done_i) state_d = ST_WAIT_REQ;
            ST_WAIT_REQ:   if (req_event_i) state_d = ST_DESCR;
            ST_DESCR:      if (send_done_i) state_d = ST_WAIT_ALLOC;
            ST_WAIT_ALLOC: if (alloc_event_i) state_d = ST_TEXT;
            ST_TEXT:       if (take) state_d = ST_DATA;
            ST_DATA:       if (take) state_d = ST_BSS;
            ST_BSS:        if (take) state_d = ST_ENTRY;
            ST_ENTRY:      if (take) state_d = ST_TASK;
            ST_TASK: begin
                if (send_done_i) begin
                    state_d = last_task ? ST_WAIT_DONE : ST_TEXT;
                end
            end
            ST_WAIT_DONE:  if (complete_event_i) state_d = ST_SIZE;
            default:       state_d = ST_SIZE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= ST_SIZE;
            task_cnt_q  <= '0;
            task_idx_q  <= '0;
            req_taken_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // counts above the limit are clamped
            if (state_q == ST_COUNT && take) begin
                task_cnt_q <= (src_data_i > task_injector_pkg::MAX_TASKS)
                              ? task_injector_pkg::MAX_TASKS : src_data_i;
            end
            if (state_q == ST_WAIT_ALLOC) begin
                task_idx_q <= '0;
            end else if (state_q == ST_TASK && send_done_i && !last_task) begin
                task_idx_q <= task_idx_q + 1'b1;
            end
            if (send_done_i) begin
                req_taken_q <= 1'b0;
            end else if (send_valid_o && send_ready_i) begin
                req_taken_q <= 1'b1;
            end
        end
    end

    // preamble and size words
    always_ff @(posedge clk_i) begin
        if (take) begin
            case (state_q)
                ST_SIZE:  graph_size_o <= src_data_i;
                ST_HASH:  app_hash_o   <= src_data_i;
                ST_TEXT:  text_size_o  <= src_data_i;
                ST_DATA:  data_size_o  <= src_data_i;
                ST_BSS:   bss_size_o   <= src_data_i;
                ST_ENTRY: entry_o      <= src_data_i;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // send requests
    ////////////////////////////////////////

    // one request per send state, withdrawn once the sender takes it
    assign send_valid_o = (state_q inside {ST_DATA_AV, ST_DESCR, ST_TASK}) && !req_taken_q;

    always_comb begin
        case (state_q)
            ST_DESCR: send_kind_o = task_injector_pkg::PKT_DESCRIPTOR;
            ST_TASK:  send_kind_o = task_injector_pkg::PKT_TASK_ALLOC;
            default:  send_kind_o = task_injector_pkg::PKT_DATA_AV;
        endcase
    end

    assign task_cnt_o = task_cnt_q;
    assign task_idx_o = task_idx_q;

endmodule

//--- packet_receiver.sv
// packet receiver of the task injector
// buffers incoming flits, drains long packets, decodes services
`timescale 1ns/1ns

module packet_receiver (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          noc_rx_i,
    input  logic                                          noc_eop_i,
    output logic                                          noc_credit_o,
    input  task_injector_pkg::flit_t                      noc_data_i,
    output logic                                          req_event_o,
    output task_injector_pkg::addr_t                      req_addr_o,
    output logic [15:0]                                   req_port_o,
    output logic                                          alloc_event_o,
    output logic [7:0]                                    app_id_o,
    output task_injector_pkg::addr_t [task_injector_pkg::MAX_TASKS-1:0] task_addr_o,
    output logic                                          complete_event_o
);

    typedef enum logic [1:0] {
        RX_PACKET = 2'd0,
        RX_DROP   = 2'd1,
        RX_DECODE = 2'd2
    } rx_state_t;

    rx_state_t                state_q;
    task_injector_pkg::flit_t buf_q [task_injector_pkg::IN_BUF_FLITS];
    logic [3:0]               idx_q;
    logic                     fire;
    logic                     is_delivery;
    logic [7:0]               kernel_svc;

    assign noc_credit_o = (state_q != RX_DECODE);
    assign fire         = noc_rx_i && noc_credit_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RX_PACKET;
            idx_q   <= '0;
        end else begin
            case (state_q)
                RX_PACKET: begin
                    if (fire) begin
                        idx_q <= idx_q + 4'd1;
                        if (noc_eop_i) begin
                            state_q <= RX_DECODE;
                        end else if (idx_q == 4'(task_injector_pkg::IN_BUF_FLITS - 1)) begin
                            state_q <= RX_DROP;
                        end
                    end
                end
                // rest of an over-long packet is thrown away
                RX_DROP: begin
                    if (fire && noc_eop_i) begin
                        state_q <= RX_PACKET;
                        idx_q   <= '0;
                    end
                end
                default: begin
                    state_q <= RX_PACKET;
                    idx_q   <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_PACKET && fire) begin
            buf_q[idx_q] <= noc_data_i;
        end
    end

    ////////////////////////////////////////
    // service decode
    ////////////////////////////////////////

    assign kernel_svc  = buf_q[5][23:16];
    assign is_delivery = (state_q == RX_DECODE)
                         && (buf_q[0][23:16] == task_injector_pkg::MESSAGE_DELIVERY);

    assign req_event_o      = (state_q == RX_DECODE)
                              && (buf_q[0][23:16] == task_injector_pkg::MESSAGE_REQUEST);
    assign alloc_event_o    = is_delivery
                              && (kernel_svc == task_injector_pkg::APP_ALLOCATION_REQUEST);
    assign complete_event_o = is_delivery
                              && (kernel_svc == task_injector_pkg::APP_MAPPING_COMPLETE);

    // fields stay valid after the buffer is reused
    always_ff @(posedge clk_i) begin
        if (req_event_o) begin
            req_addr_o <= buf_q[1][15:0];
            req_port_o <= buf_q[2][31:16];
        end
        if (alloc_event_o) begin
            app_id_o <= buf_q[5][31:24];
            for (int i = 0; i < task_injector_pkg::MAX_TASKS; i++) begin
                task_addr_o[i] <= buf_q[6+i][15:0];
            end
        end
    end

endmodule

//--- packet_sender.sv
// packet sender of the task injector
// latches a header per request, then serialises header and source body
`timescale 1ns/1ns

module packet_sender (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  task_injector_pkg::addr_t                      mapper_addr_i,
    input  logic                                          send_valid_i,
    input  task_injector_pkg::pkt_kind_t                  send_kind_i,
    output logic                                          send_ready_o,
    output logic                                          send_done_o,
    input  task_injector_pkg::flit_t                      graph_size_i,
    input  task_injector_pkg::flit_t                      app_hash_i,
    input  task_injector_pkg::flit_t                      task_cnt_i,
    input  task_injector_pkg::flit_t                      text_size_i,
    input  task_injector_pkg::flit_t                      data_size_i,
    input  task_injector_pkg::flit_t                      bss_size_i,
    input  task_injector_pkg::flit_t                      entry_i,
    input  logic [task_injector_pkg::TASK_IDX_W-1:0]      task_idx_i,
    input  task_injector_pkg::addr_t                      req_addr_i,
    input  logic [15:0]                                   req_port_i,
    input  logic [7:0]                                    app_id_i,
    input  task_injector_pkg::addr_t [task_injector_pkg::MAX_TASKS-1:0] task_addr_i,
    input  logic                                          src_valid_i,
    output logic                                          src_body_ready_o,
    input  task_injector_pkg::flit_t                      src_data_i,
    output logic                                          noc_tx_o,
    output logic                                          noc_eop_o,
    output task_injector_pkg::flit_t                      noc_data_o,
    input  logic                                          noc_credit_i
);

    task_injector_pkg::flit_t hdr_q [task_injector_pkg::DESCR_HDR_FLITS];
    task_injector_pkg::flit_t body_len_q;
    task_injector_pkg::flit_t body_cnt_q;
    task_injector_pkg::flit_t text_rnd;
    task_injector_pkg::flit_t data_rnd;
    logic [3:0]               hdr_len_q;
    logic [3:0]               idx_q;
    logic                     busy_q;
    logic                     in_body;
    logic                     last;
    logic                     fire;

    // code size in words, text and data rounded up to whole words
    assign text_rnd = (text_size_i + 32'd3) & 32'hFFFF_FFFC;
    assign data_rnd = (data_size_i + 32'd3) & 32'hFFFF_FFFC;

    assign send_ready_o = !busy_q;

    ////////////////////////////////////////
    // header latch
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (send_valid_i && send_ready_o) begin
            case (send_kind_i)
                task_injector_pkg::PKT_DESCRIPTOR: begin
                    hdr_q[0]   <= {8'h00, task_injector_pkg::MESSAGE_DELIVERY, req_addr_i};
                    hdr_q[1]   <= task_injector_pkg::INJECTOR_ADDRESS;
                    hdr_q[2]   <= {16'hFFFF, req_port_i};
                    hdr_q[3]   <= '0;
                    hdr_q[4]   <= (graph_size_i + 32'd3) << 2;
                    hdr_q[5]   <= {task_cnt_i[7:0], task_injector_pkg::NEW_APP, 16'h0000};
                    hdr_q[6]   <= task_injector_pkg::INJECTOR_ADDRESS;
                    hdr_q[7]   <= app_hash_i;
                    body_len_q <= graph_size_i;
                end
                task_injector_pkg::PKT_TASK_ALLOC: begin
                    hdr_q[0]   <= {8'h00, task_injector_pkg::TASK_ALLOCATION,
                                   task_addr_i[task_idx_i]};
                    hdr_q[1]   <= entry_i;
                    hdr_q[2]   <= text_size_i;
                    hdr_q[3]   <= data_size_i;
                    hdr_q[4]   <= bss_size_i;
                    hdr_q[5]   <= {app_id_i, 5'b0, task_idx_i, mapper_addr_i};
                    hdr_q[6]   <= '0;
                    body_len_q <= (text_rnd + data_rnd) >> 2;
                end
                default: begin
                    hdr_q[0]   <= {8'h00, task_injector_pkg::DATA_AV, mapper_addr_i};
                    hdr_q[1]   <= task_injector_pkg::INJECTOR_ADDRESS;
                    hdr_q[2]   <= {16'hFFFF, 16'h0000};
                    body_len_q <= '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // serialisation
    ////////////////////////////////////////

    assign in_body          = busy_q && (idx_q == hdr_len_q);
    assign src_body_ready_o = in_body && noc_credit_i;
    assign noc_tx_o         = busy_q && (in_body ? src_valid_i : 1'b1);
    assign noc_data_o       = in_body ? src_data_i : hdr_q[idx_q[2:0]];
    assign fire             = noc_tx_o && noc_credit_i;

    // last header flit ends the packet when the body is empty
    assign last = in_body ? (body_cnt_q == body_len_q - 32'd1)
                          : (idx_q == hdr_len_q - 4'd1 && body_len_q == '0);

    assign noc_eop_o   = noc_tx_o && last;
    assign send_done_o = fire && last;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            hdr_len_q  <= '0;
            idx_q      <= '0;
            body_cnt_q <= '0;
        end else if (send_valid_i && send_ready_o) begin
            busy_q     <= 1'b1;
            idx_q      <= '0;
            body_cnt_q <= '0;
            case (send_kind_i)
                task_injector_pkg::PKT_DESCRIPTOR:
                    hdr_len_q <= 4'(task_injector_pkg::DESCR_HDR_FLITS);
                task_injector_pkg::PKT_TASK_ALLOC:
                    hdr_len_q <= 4'(task_injector_pkg::ALLOC_HDR_FLITS);
                default:
                    hdr_len_q <= 4'(task_injector_pkg::DATA_AV_FLITS);
            endcase
        end else if (fire) begin
            if (last) begin
                busy_q <= 1'b0;
            end
            if (in_body) begin
                body_cnt_q <= body_cnt_q + 32'd1;
            end else begin
                idx_q <= idx_q + 4'd1;
            end
        end
    end

endmodule

//--- task_injector.f
task_injector_pkg.sv
injector_ctrl.sv
packet_sender.sv
packet_receiver.sv
task_injector.sv
tb_task_injector.sv

//--- task_injector.sv
// top level of the task injector
// sequencer, sender and receiver between a source port and the NoC
`timescale 1ns/1ns

module task_injector (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  task_injector_pkg::addr_t mapper_addr_i,
    input  logic                     src_valid_i,
    output logic                     src_ready_o,
    input  task_injector_pkg::flit_t src_data_i,
    output logic                     noc_tx_o,
    output logic                     noc_eop_o,
    output task_injector_pkg::flit_t noc_data_o,
    input  logic                     noc_credit_i,
    input  logic                     noc_rx_i,
    input  logic                     noc_eop_i,
    input  task_injector_pkg::flit_t noc_data_i,
    output logic                     noc_credit_o
);

    logic                         ctrl_src_ready, body_src_ready;
    logic                         send_valid, send_ready, send_done;
    task_injector_pkg::pkt_kind_t send_kind;
    task_injector_pkg::flit_t     graph_size, app_hash, task_cnt;
    task_injector_pkg::flit_t     text_size, data_size, bss_size, entry;
    logic [task_injector_pkg::TASK_IDX_W-1:0] task_idx;

    logic                         req_event, alloc_event, complete_event;
    task_injector_pkg::addr_t     req_addr;
    logic [15:0]                  req_port;
    logic [7:0]                   app_id;
    task_injector_pkg::addr_t [task_injector_pkg::MAX_TASKS-1:0] task_addr;

    // the sequencer never reads the source during a packet body
    assign src_ready_o = ctrl_src_ready | body_src_ready;

    injector_ctrl u_ctrl (
        .clk_i, .rst_ni, .src_valid_i, .src_ready_o(ctrl_src_ready), .src_data_i,
        .send_valid_o(send_valid), .send_kind_o(send_kind), .send_ready_i(send_ready),
        .send_done_i(send_done), .req_event_i(req_event), .alloc_event_i(alloc_event),
        .complete_event_i(complete_event), .graph_size_o(graph_size),
        .app_hash_o(app_hash), .task_cnt_o(task_cnt), .text_size_o(text_size),
        .data_size_o(data_size), .bss_size_o(bss_size), .entry_o(entry),
        .task_idx_o(task_idx)
    );

    packet_sender u_sender (
        .clk_i, .rst_ni, .mapper_addr_i, .send_valid_i(send_valid),
        .send_kind_i(send_kind), .send_ready_o(send_ready), .send_done_o(send_done),
        .graph_size_i(graph_size), .app_hash_i(app_hash), .task_cnt_i(task_cnt),
        .text_size_i(text_size), .data_size_i(data_size), .bss_size_i(bss_size),
        .entry_i(entry), .task_idx_i(task_idx), .req_addr_i(req_addr),
        .req_port_i(req_port), .app_id_i(app_id), .task_addr_i(task_addr),
        .src_valid_i, .src_body_ready_o(body_src_ready), .src_data_i,
        .noc_tx_o, .noc_eop_o, .noc_data_o, .noc_credit_i
    );

    packet_receiver u_receiver (
        .clk_i, .rst_ni, .noc_rx_i, .noc_eop_i, .noc_credit_o, .noc_data_i,
        .req_event_o(req_event), .req_addr_o(req_addr), .req_port_o(req_port),
        .alloc_event_o(alloc_event), .app_id_o(app_id), .task_addr_o(task_addr),
        .complete_event_o(complete_event)
    );

endmodule

//--- task_injector_pkg.sv
// shared widths, limits and service codes for the task injector
// also holds the flit, address and packet-kind types
package task_injector_pkg;

    ////////////////////////////////////////
    // widths and limits
    ////////////////////////////////////////

    localparam int FLIT_W = 32;
    localparam int ADDR_W = 16;

    localparam logic [31:0] INJECTOR_ADDRESS = 32'hE000_0000;

    // task count is clamped to this value
    localparam int MAX_TASKS  = 8;
    localparam int TASK_IDX_W = 3;

    // six header flits plus one address per task
    localparam int IN_BUF_FLITS = 6 + MAX_TASKS;

    localparam int DATA_AV_FLITS   = 3;
    localparam int DESCR_HDR_FLITS = 8;
    localparam int ALLOC_HDR_FLITS = 7;

    ////////////////////////////////////////
    // service codes
    ////////////////////////////////////////

    // network services, flit 0 bits 23:16
    localparam logic [7:0] MESSAGE_DELIVERY = 8'h10;
    localparam logic [7:0] MESSAGE_REQUEST  = 8'h20;
    localparam logic [7:0] DATA_AV          = 8'h31;

    // kernel services, flit 5 bits 23:16 of a delivery
    localparam logic [7:0] TASK_ALLOCATION        = 8'h40;
    localparam logic [7:0] NEW_APP                = 8'h42;
    localparam logic [7:0] APP_ALLOCATION_REQUEST = 8'h43;
    localparam logic [7:0] APP_MAPPING_COMPLETE   = 8'h44;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        PKT_DATA_AV    = 2'd0,
        PKT_DESCRIPTOR = 2'd1,
        PKT_TASK_ALLOC = 2'd2
    } pkt_kind_t;

endpackage

//--- tb_task_injector.sv
// testbench for the task injector
// source driver, mapper model, expected-flit queue and watchdog
`timescale 1ns/1ns

module tb_task_injector;

    localparam int NUM_APPS = 2;

    logic                     clk_i;
    logic                     rst_ni;
    task_injector_pkg::addr_t mapper_addr_i;
    logic                     src_valid_i, src_ready_o;
    task_injector_pkg::flit_t src_data_i;
    logic                     noc_tx_o, noc_eop_o, noc_credit_i;
    task_injector_pkg::flit_t noc_data_o;
    logic                     noc_rx_i, noc_eop_i, noc_credit_o;
    task_injector_pkg::flit_t noc_data_i;

    // queue entries are {eop, flit}
    logic [32:0]              exp_q [$];
    logic [32:0]              rx_q [$];
    task_injector_pkg::flit_t src_q [$];
    logic                     exp_valid, exp_eop;
    task_injector_pkg::flit_t exp_data;
    logic                     out_go = 1'b0;
    logic                     src_go = 1'b0;
    logic                     rx_go = 1'b0;
    integer                   seed = 77805;
    int                       watchdog_cycles;

    task_injector DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // reporting and checks
    ////////////////////////////////////////

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s at %0t ns", what, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else report_value(name, 32'(got), 32'(want));
    endtask

    // every flit that leaves the injector is the head of the expected queue
    flit_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (noc_tx_o && noc_credit_i) |-> exp_valid)
        else report_problem("a flit left the injector while none was expected");
    flit_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (noc_tx_o && noc_credit_i && exp_valid) |-> (noc_data_o == exp_data))
        else report_value("noc_data_o", $sampled(noc_data_o), $sampled(exp_data));
    flit_eop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (noc_tx_o && noc_credit_i && exp_valid) |-> (noc_eop_o == exp_eop))
        else report_value("noc_eop_o", 32'($sampled(noc_eop_o)), 32'($sampled(exp_eop)));

    ////////////////////////////////////////
    // test parameters and packet formats
    ////////////////////////////////////////

    function automatic int graph_of(input int a);
        return 5 - 2 * a;
    endfunction

    function automatic int tasks_of(input int a);
        return 3 - a;
    endfunction

    function automatic task_injector_pkg::flit_t text_of(input int a, input int t);
        if (a == 1 && t == 1) return '0;
        return 32'(13 + 6 * t + 11 * a);
    endfunction

    function automatic task_injector_pkg::flit_t data_of(input int a, input int t);
        if (a == 1 && t == 1) return '0;
        return 32'(5 + 3 * t + 2 * a);
    endfunction

    function automatic task_injector_pkg::addr_t addr_of(input int a, input int t);
        return 16'(16'h0200 + a * 16'h0100 + t * 16'h0011);
    endfunction

    function automatic task_injector_pkg::flit_t round4(input task_injector_pkg::flit_t x);
        return ((x + 32'd3) / 32'd4) * 32'd4;
    endfunction

    // code body in words, text and data each rounded up to four bytes
    function automatic int body_words(input task_injector_pkg::flit_t text,
                                      input task_injector_pkg::flit_t data);
        return int'((round4(text) + round4(data)) / 32'd4);
    endfunction

    function automatic int total_flits();
        int n;
        n = 0;
        for (int a = 0; a < NUM_APPS; a++) begin
            n += task_injector_pkg::DATA_AV_FLITS + task_injector_pkg::DESCR_HDR_FLITS;
            n += graph_of(a);
            for (int t = 0; t < tasks_of(a); t++) begin
                n += task_injector_pkg::ALLOC_HDR_FLITS;
                n += body_words(text_of(a, t), data_of(a, t));
            end
        end
        return n;
    endfunction

    function automatic void refresh_head();
        exp_valid = (exp_q.size() != 0);
        exp_data  = exp_valid ? exp_q[0][31:0] : '0;
        exp_eop   = exp_valid ? exp_q[0][32] : 1'b0;
    endfunction

    function automatic void push_exp(input task_injector_pkg::flit_t f, input logic eop);
        exp_q.push_back({eop, f});
        refresh_head();
    endfunction

    function automatic void queue_task(input int a, input int t);
        task_injector_pkg::flit_t text, data, bss, entry, w;
        int                       len;
        text  = text_of(a, t);
        data  = data_of(a, t);
        bss   = 32'h40 + 32'(t);
        entry = 32'h1000 + 32'(4 * t);
        len   = body_words(text, data);
        src_q.push_back(text);
        src_q.push_back(data);
        src_q.push_back(bss);
        src_q.push_back(entry);
        push_exp({8'h00, task_injector_pkg::TASK_ALLOCATION, addr_of(a, t)}, 1'b0);
        push_exp(entry, 1'b0);
        push_exp(text, 1'b0);
        push_exp(data, 1'b0);
        push_exp(bss, 1'b0);
        push_exp({8'(8'h21 + a), 8'(t), mapper_addr_i}, 1'b0);
        // empty body puts eop on the last header flit
        push_exp('0, len == 0);
        for (int i = 0; i < len; i++) begin
            w = $random(seed);
            src_q.push_back(w);
            push_exp(w, i == len - 1);
        end
    endfunction

    ////////////////////////////////////////
    // mapper packets
    ////////////////////////////////////////

    function automatic void rx_flit(input task_injector_pkg::flit_t f, input logic eop);
        rx_q.push_back({eop, f});
    endfunction

    function automatic void send_delivery(input int a, input logic [7:0] svc, input int n);
        rx_flit({8'h00, task_injector_pkg::MESSAGE_DELIVERY, 16'h0000}, 1'b0);
        rx_flit({16'h0000, mapper_addr_i}, 1'b0);
        rx_flit('0, 1'b0);
        rx_flit('0, 1'b0);
        rx_flit(32'(4 * n), 1'b0);
        rx_flit({8'(8'h21 + a), svc, 16'h0000}, n == 0);
        for (int t = 0; t < n; t++) begin
            rx_flit({16'h0000, addr_of(a, t)}, t == n - 1);
        end
    endfunction

    // too long for the buffer, so its allocation must be dropped
    function automatic void send_long();
        for (int i = 0; i < 20; i++) begin
            if (i == 0) rx_flit({8'h00, task_injector_pkg::MESSAGE_DELIVERY, 16'h0}, 1'b0);
            else if (i == 5) rx_flit({8'hEE, task_injector_pkg::APP_ALLOCATION_REQUEST,
                                      16'h0}, 1'b0);
            else rx_flit(32'h0000_0F0F, i == 19);
        end
    endfunction

    function automatic void send_unknown();
        rx_flit({8'h00, 8'h5A, 16'h0000}, 1'b0);
        for (int i = 1; i < 6; i++) begin
            rx_flit({8'hEE, task_injector_pkg::APP_ALLOCATION_REQUEST, 16'h0}, i == 5);
        end
    endfunction

    task automatic wait_drain();
        while (exp_q.size() != 0 || rx_q.size() != 0) @(negedge clk_i);
    endtask

    task automatic run_app(input int a);
        task_injector_pkg::flit_t w;
        int                       g;
        g = graph_of(a);
        src_q.push_back(32'(g));
        src_q.push_back(32'hA5A5_0000 + 32'(a));
        src_q.push_back(32'(tasks_of(a)));
        push_exp({8'h00, task_injector_pkg::DATA_AV, mapper_addr_i}, 1'b0);
        push_exp(task_injector_pkg::INJECTOR_ADDRESS, 1'b0);
        push_exp({16'hFFFF, 16'h0000}, 1'b1);
        wait_drain();
        // descriptor answers the mapper's request
        push_exp({8'h00, task_injector_pkg::MESSAGE_DELIVERY, mapper_addr_i}, 1'b0);
        push_exp(task_injector_pkg::INJECTOR_ADDRESS, 1'b0);
        push_exp({16'hFFFF, 16'(16'h0A0B + a)}, 1'b0);
        push_exp('0, 1'b0);
        push_exp(32'(4 * (g + 3)), 1'b0);
        push_exp({8'(tasks_of(a)), task_injector_pkg::NEW_APP, 16'h0000}, 1'b0);
        push_exp(task_injector_pkg::INJECTOR_ADDRESS, 1'b0);
        push_exp(32'hA5A5_0000 + 32'(a), 1'b0);
        for (int i = 0; i < g; i++) begin
            w = $random(seed);
            src_q.push_back(w);
            push_exp(w, i == g - 1);
        end
        rx_flit({8'h00, task_injector_pkg::MESSAGE_REQUEST, 16'h0000}, 1'b0);
        rx_flit({16'h0000, mapper_addr_i}, 1'b0);
        rx_flit({16'(16'h0A0B + a), 16'h0000}, 1'b1);
        wait_drain();
        for (int t = 0; t < tasks_of(a); t++) queue_task(a, t);
        send_long();
        send_unknown();
        send_delivery(a, task_injector_pkg::APP_ALLOCATION_REQUEST, tasks_of(a));
        wait_drain();
        send_delivery(a, task_injector_pkg::APP_MAPPING_COMPLETE, 0);
    endtask

    ////////////////////////////////////////
    // drivers and monitor
    ////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk_i);
            noc_credit_i = ($random(seed) & 3) != 0;
        end
    end

    // source words hold until taken, gaps are random
    initial begin
        forever begin
            @(negedge clk_i);
            if (src_go) begin
                void'(src_q.pop_front());
                src_valid_i = 1'b0;
            end
            if (!src_valid_i && src_q.size() != 0 && ($random(seed) & 3) != 0) begin
                src_valid_i = 1'b1;
                src_data_i  = src_q[0];
            end
            #1;
            src_go = src_valid_i && src_ready_o;
        end
    end

    initial begin
        forever begin
            @(negedge clk_i);
            if (rx_go) void'(rx_q.pop_front());
            noc_rx_i   = (rx_q.size() != 0);
            noc_eop_i  = noc_rx_i ? rx_q[0][32] : 1'b0;
            noc_data_i = noc_rx_i ? rx_q[0][31:0] : '0;
            #1;
            rx_go = noc_rx_i && noc_credit_o;
        end
    end

    initial begin
        forever begin
            @(negedge clk_i);
            if (out_go) begin
                void'(exp_q.pop_front());
                refresh_head();
            end
            #1;
            out_go = rst_ni && noc_tx_o && noc_credit_i;
        end
    end

    initial begin
        watchdog_cycles = 40 * total_flits() + 1000;
        repeat (watchdog_cycles) @(posedge clk_i);
        report_problem("watchdog expired before the injector finished");
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_ni        = 1'b0;
        mapper_addr_i = 16'h0101;
        src_valid_i   = 1'b0;
        src_data_i    = '0;
        noc_credit_i  = 1'b0;
        noc_rx_i      = 1'b0;
        noc_eop_i     = 1'b0;
        noc_data_i    = '0;
        refresh_head();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("noc_eop_o", noc_eop_o, 1'b0);
        check_bit("src_ready_o", src_ready_o, 1'b1);
        check_bit("noc_credit_o", noc_credit_o, 1'b1);
        for (int a = 0; a < NUM_APPS; a++) run_app(a);
        // back to waiting for a preamble once completion is decoded
        while (rx_q.size() != 0 || !src_ready_o) @(negedge clk_i);
        if (exp_q.size() == 0 && src_q.size() == 0 && !noc_tx_o) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_problem("run ended with words left in the source or expected queue");
        end
    end

endmodule
